/* Bender.yml */
package:
  name: back_end

sources:
  - target: rtl
    files:
      - hw/isaPkg.sv
      - hw/pipePkg.sv
      - hw/pipeIf.sv
      - hw/alu.sv
      - hw/regFile.sv
      - hw/forwardUnit.sv
      - hw/execStage.sv
      - hw/memStage.sv
      - hw/backEnd.sv
  - target: test
    files:
      - tb/backEnd_props.sv
      - tb/backEndTb.sv

/* filelist.f */
hw/isaPkg.sv
hw/pipePkg.sv
hw/pipeIf.sv
hw/alu.sv
hw/regFile.sv
hw/forwardUnit.sv
hw/execStage.sv
hw/memStage.sv
hw/backEnd.sv
tb/backEnd_props.sv
tb/backEndTb.sv

/* hw/alu.sv */
`timescale 1ns/1ns
`default_nettype none

module alu import isaPkg::*; #(
    parameter int dataWidth = 18
) (
    input  logic [dataWidth-1:0] opA,
    input  logic [dataWidth-1:0] opB,
    input  aluOp_e               op,
    output logic [dataWidth-1:0] result,
    output logic                 zero
);

    logic [3:0] shamt;
    logic       lessThan;

    assign shamt    = opB[3:0];                   // Only the low 4 bits shift
    assign lessThan = $signed(opA) < $signed(opB);

    always_comb begin
        case (op)
            aluAdd:  result = opA + opB;
            aluSub:  result = opA - opB;
            aluAnd:  result = opA & opB;
            aluOr:   result = opA | opB;
            aluXor:  result = opA ^ opB;
            aluSlt:  result = {{(dataWidth-1){1'b0}}, lessThan};
            aluSll:  result = opA << shamt;
            aluSrl:  result = opA >> shamt;
            default: result = '0;
        endcase
    end

    // Used by the branch decision
    assign zero = (result == '0);

endmodule

`default_nettype wire

/* hw/backEnd.sv */
`timescale 1ns/1ns
`default_nettype none

module backEnd import isaPkg::*, pipePkg::*; #(
    parameter int dataWidth = 18,
    parameter int dmemDepth = 64
) (
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 issueValid,
    input  aluOp_e               issueOp,
    input  logic                 issueAluSrc,
    input  logic                 issueRegWrite,
    input  logic                 issueMemWrite,
    input  resSrc_e              issueResSrc,
    input  logic                 issueBranch,
    input  logic [regAddrW-1:0]  issueRs1,
    input  logic [regAddrW-1:0]  issueRs2,
    input  logic [regAddrW-1:0]  issueRd,
    input  logic [dataWidth-1:0] issueImm,
    input  logic [dataWidth-1:0] issuePc,
    output logic                 branchTaken,
    output logic [dataWidth-1:0] branchTarget,
    output logic                 commitValid,
    output logic [regAddrW-1:0]  commitRd,
    output logic [dataWidth-1:0] commitData
);

    logic [dataWidth-1:0] rd1;
    logic [dataWidth-1:0] rd2;
    fwdSel_e              fwdA;
    fwdSel_e              fwdB;

    exMemIf #(.dataWidth(dataWidth)) exMem ();
    memWbIf #(.dataWidth(dataWidth)) memWb ();

    regFile #(.dataWidth(dataWidth)) regFileInst (
        .clk (clk),
        .rst (rst),
        .rs1 (issueRs1),
        .rs2 (issueRs2),
        .wb  (memWb),
        .rd1 (rd1),
        .rd2 (rd2)
    );

    forwardUnit fwdInst (
        .rs1   (issueRs1),
        .rs2   (issueRs2),
        .exMem (exMem),
        .memWb (memWb),
        .fwdA  (fwdA),
        .fwdB  (fwdB)
    );

    execStage #(.dataWidth(dataWidth)) execInst (
        .clk          (clk),
        .rst          (rst),
        .valid        (issueValid),
        .op           (issueOp),
        .aluSrc       (issueAluSrc),
        .regWrite     (issueRegWrite),
        .memWrite     (issueMemWrite),
        .resSrc       (issueResSrc),
        .branch       (issueBranch),
        .rd           (issueRd),
        .imm          (issueImm),
        .pc           (issuePc),
        .rd1          (rd1),
        .rd2          (rd2),
        .fwdA         (fwdA),
        .fwdB         (fwdB),
        .memWb        (memWb),
        .branchTaken  (branchTaken),
        .branchTarget (branchTarget),
        .exMem        (exMem)
    );

    memStage #(
        .dataWidth (dataWidth),
        .dmemDepth (dmemDepth)
    ) memInst (
        .clk   (clk),
        .rst   (rst),
        .exMem (exMem),
        .memWb (memWb)
    );

    // Commit port mirrors the writeback register
    assign commitValid = memWb.valid && memWb.regWrite;
    assign commitRd    = memWb.rd;
    assign commitData  = memWb.result;

endmodule

`default_nettype wire

/* hw/execStage.sv */
`timescale 1ns/1ns
`default_nettype none

module execStage import isaPkg::*, pipePkg::*; #(
    parameter int dataWidth = 18
) (
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 valid,
    input  aluOp_e               op,
    input  logic                 aluSrc,
    input  logic                 regWrite,
    input  logic                 memWrite,
    input  resSrc_e              resSrc,
    input  logic                 branch,
    input  logic [regAddrW-1:0]  rd,
    input  logic [dataWidth-1:0] imm,
    input  logic [dataWidth-1:0] pc,
    input  logic [dataWidth-1:0] rd1,
    input  logic [dataWidth-1:0] rd2,
    input  fwdSel_e              fwdA,
    input  fwdSel_e              fwdB,
    memWbIf.mon                  memWb,
    output logic                 branchTaken,
    output logic [dataWidth-1:0] branchTarget,
    exMemIf.src                  exMem
);

    logic [dataWidth-1:0] srcA;
    logic [dataWidth-1:0] fwdDataB; // Forwarded rs2 that doubles as store data
    logic [dataWidth-1:0] srcB;
    logic [dataWidth-1:0] aluResult;
    logic                 aluZero;

    // 3-to-1 forwarding mux used for both operands
    function automatic logic [dataWidth-1:0] pickOperand(input fwdSel_e sel,
                                                          input logic [dataWidth-1:0] regVal,
                                                          input logic [dataWidth-1:0] wbVal,
                                                          input logic [dataWidth-1:0] memVal);
        case (sel)
            fwdWb:   return wbVal;
            fwdMem:  return memVal;
            default: return regVal;
        endcase
    endfunction

    // The memory-stage value is read back from our own pipeline register
    assign srcA     = pickOperand(fwdA, rd1, memWb.result, exMem.aluResult);
    assign fwdDataB = pickOperand(fwdB, rd2, memWb.result, exMem.aluResult);
    assign srcB     = aluSrc ? imm : fwdDataB;

    alu #(.dataWidth(dataWidth)) aluInst (
        .opA    (srcA),
        .opB    (srcB),
        .op     (op),
        .result (aluResult),
        .zero   (aluZero)
    );

    assign branchTaken  = valid && branch && aluZero;
    assign branchTarget = pc + imm;

    // Control half of the execute/memory register
    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            exMem.valid    <= 1'b0;
            exMem.regWrite <= 1'b0;
            exMem.memWrite <= 1'b0;
            exMem.resSrc   <= resAlu;
            exMem.rd       <= '0;
        end else begin
            exMem.valid    <= valid;
            exMem.regWrite <= regWrite;
            exMem.memWrite <= memWrite;
            exMem.resSrc   <= resSrc;
            exMem.rd       <= rd;
        end
    end

    always_ff @(posedge clk) begin
        exMem.aluResult <= aluResult;
        exMem.writeData <= fwdDataB;
    end

endmodule

`default_nettype wire

/* hw/forwardUnit.sv */
`timescale 1ns/1ns
`default_nettype none

module forwardUnit import isaPkg::*, pipePkg::*; (
    input  logic [regAddrW-1:0] rs1,
    input  logic [regAddrW-1:0] rs2,
    exMemIf.mon                 exMem,
    memWbIf.mon                 memWb,
    output fwdSel_e             fwdA,
    output fwdSel_e             fwdB
);

    logic memFwdOk; // Memory-stage entry may forward
    logic wbFwdOk;

    // A load in the memory stage has no data yet, so only ALU results qualify
    assign memFwdOk = exMem.valid && exMem.regWrite && (exMem.rd != '0) &&
                      (exMem.resSrc == resAlu);
    assign wbFwdOk  = memWb.valid && memWb.regWrite && (memWb.rd != '0);

    function automatic fwdSel_e pickSrc(input logic [regAddrW-1:0] rs,
                                        input logic                memOk,
                                        input logic [regAddrW-1:0] memRd,
                                        input logic                wbOk,
                                        input logic [regAddrW-1:0] wbRd);
        if (memOk && memRd == rs) begin
            return fwdMem;                      // Youngest value wins
        end else if (wbOk && wbRd == rs) begin
            return fwdWb;
        end
        return fwdReg;
    endfunction

    assign fwdA = pickSrc(rs1, memFwdOk, exMem.rd, wbFwdOk, memWb.rd);
    assign fwdB = pickSrc(rs2, memFwdOk, exMem.rd, wbFwdOk, memWb.rd);

endmodule

`default_nettype wire

/* hw/isaPkg.sv */
`default_nettype none

package isaPkg;

    // Register index width, 32 architectural registers
    localparam int regAddrW = 5;

    // ALU operations as issued by the front end
    typedef enum logic [2:0] {
        aluAdd = 3'd0,
        aluSub = 3'd1,
        aluAnd = 3'd2,
        aluOr  = 3'd3,
        aluXor = 3'd4,
        aluSlt = 3'd5, // Signed compare
        aluSll = 3'd6,
        aluSrl = 3'd7
    } aluOp_e;

    // Where the written-back value comes from
    typedef enum logic {
        resAlu = 1'b0,
        resMem = 1'b1  // Load data
    } resSrc_e;

endpackage

`default_nettype wire

/* hw/memStage.sv */
`timescale 1ns/1ns
`default_nettype none

module memStage import isaPkg::*; #(
    parameter int dataWidth = 18,
    parameter int dmemDepth = 64  // Power of two
) (
    input  logic clk,
    input  logic rst,
    exMemIf.dst  exMem,
    memWbIf.src  memWb
);

    localparam int addrW = $clog2(dmemDepth);

    logic [dataWidth-1:0] dmem [dmemDepth];
    logic [addrW-1:0]     addr;
    logic [dataWidth-1:0] loadData;
    logic [dataWidth-1:0] result;

    assign addr     = exMem.aluResult[addrW-1:0]; // Word address wraps at the depth
    assign loadData = dmem[addr];
    assign result   = (exMem.resSrc == resMem) ? loadData : exMem.aluResult;

    // Memory starts out all zero, loads from unwritten words return zero
    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            for (int i = 0; i < dmemDepth; i++) begin
                dmem[i] <= '0;
            end
        end else if (exMem.valid && exMem.memWrite) begin
            dmem[addr] <= exMem.writeData;
        end
    end

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            memWb.valid    <= 1'b0;
            memWb.regWrite <= 1'b0;
            memWb.rd       <= '0;
        end else begin
            memWb.valid    <= exMem.valid;
            memWb.regWrite <= exMem.regWrite;
            memWb.rd       <= exMem.rd;
        end
    end

    always_ff @(posedge clk) begin
        memWb.result <= result;
    end

endmodule

`default_nettype wire

/* hw/pipeIf.sv */
`timescale 1ns/1ns
`default_nettype none

// Execute/memory pipeline register
interface exMemIf import isaPkg::*; #(
    parameter int dataWidth = 18
) ();
    logic                 valid;
    logic                 regWrite;
    logic                 memWrite;
    resSrc_e              resSrc;
    logic [regAddrW-1:0]  rd;
    logic [dataWidth-1:0] aluResult;
    logic [dataWidth-1:0] writeData; // Store data

    modport src (output valid, regWrite, memWrite, resSrc, rd, aluResult, writeData);
    modport dst (input valid, regWrite, memWrite, resSrc, rd, aluResult, writeData);
    modport mon (input valid, regWrite, resSrc, rd, aluResult);
endinterface

// Memory/writeback pipeline register
interface memWbIf import isaPkg::*; #(
    parameter int dataWidth = 18
) ();
    logic                 valid;
    logic                 regWrite;
    logic [regAddrW-1:0]  rd;
    logic [dataWidth-1:0] result;

    modport src (output valid, regWrite, rd, result);
    modport dst (input valid, regWrite, rd, result);
    modport mon (input valid, regWrite, rd, result);
endinterface

`default_nettype wire

/* hw/pipePkg.sv */
`default_nettype none

package pipePkg;

    // Operand source picked by the forwarding unit
    typedef enum logic [1:0] {
        fwdReg = 2'b00, // Register file read
        fwdWb  = 2'b01, // Writeback result
        fwdMem = 2'b10  // ALU result sitting in the memory stage
    } fwdSel_e;

endpackage

`default_nettype wire

/* hw/regFile.sv */
`timescale 1ns/1ns
`default_nettype none

module regFile import isaPkg::*; #(
    parameter int dataWidth = 18
) (
    input  logic                 clk,
    input  logic                 rst,
    input  logic [regAddrW-1:0]  rs1,
    input  logic [regAddrW-1:0]  rs2,
    memWbIf.dst                  wb,
    output logic [dataWidth-1:0] rd1,
    output logic [dataWidth-1:0] rd2
);

    localparam int regCount = 1 << regAddrW;

    logic [dataWidth-1:0] regs [regCount];

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            for (int i = 0; i < regCount; i++) begin
                regs[i] <= '0;
            end
        end else if (wb.valid && wb.regWrite && wb.rd != '0) begin
            regs[wb.rd] <= wb.result;
        end
    end

    // Register 0 is hardwired to zero
    assign rd1 = (rs1 == '0) ? '0 : regs[rs1];
    assign rd2 = (rs2 == '0) ? '0 : regs[rs2];

endmodule

`default_nettype wire

/* tb/backEndTb.sv */
`timescale 1ns/1ns
`default_nettype none

module backEndTb import isaPkg::*;;

    localparam int dataWidth   = 18;
    localparam int dmemDepth   = 64;
    localparam int numInstr    = 2000;
    localparam int clkPeriod   = 4;
    localparam int resetCycles = 4;
    localparam int timeoutNs   = clkPeriod * numInstr * 2 + clkPeriod * resetCycles;
    localparam int regLimit    = 7;  // Few registers, so forwarding is frequent

    typedef struct packed {
        logic                 valid;
        logic [regAddrW-1:0]  rd;
        logic [dataWidth-1:0] data;
    } expCommit_t;

    logic                 clk;
    logic                 rst;
    logic                 issueValid;
    aluOp_e               issueOp;
    logic                 issueAluSrc;
    logic                 issueRegWrite;
    logic                 issueMemWrite;
    resSrc_e              issueResSrc;
    logic                 issueBranch;
    logic [regAddrW-1:0]  issueRs1;
    logic [regAddrW-1:0]  issueRs2;
    logic [regAddrW-1:0]  issueRd;
    logic [dataWidth-1:0] issueImm;
    logic [dataWidth-1:0] issuePc;
    logic                 branchTaken;
    logic [dataWidth-1:0] branchTarget;
    logic                 commitValid;
    logic [regAddrW-1:0]  commitRd;
    logic [dataWidth-1:0] commitData;

    // Reference state, updated in issue order
    logic [dataWidth-1:0] modelRegs [1 << regAddrW];
    logic [dataWidth-1:0] modelMem [dmemDepth];
    expCommit_t           expQ [$];
    logic                 lastWasLoad;
    logic [regAddrW-1:0]  lastLoadRd;
    int                   issued;

    backEnd #(
        .dataWidth (dataWidth),
        .dmemDepth (dmemDepth)
    ) dut (
        .clk           (clk),
        .rst           (rst),
        .issueValid    (issueValid),
        .issueOp       (issueOp),
        .issueAluSrc   (issueAluSrc),
        .issueRegWrite (issueRegWrite),
        .issueMemWrite (issueMemWrite),
        .issueResSrc   (issueResSrc),
        .issueBranch   (issueBranch),
        .issueRs1      (issueRs1),
        .issueRs2      (issueRs2),
        .issueRd       (issueRd),
        .issueImm      (issueImm),
        .issuePc       (issuePc),
        .branchTaken   (branchTaken),
        .branchTarget  (branchTarget),
        .commitValid   (commitValid),
        .commitRd      (commitRd),
        .commitData    (commitData)
    );

    initial begin
        clk = 1'b0;
        forever #(clkPeriod / 2) clk = ~clk;
    end

    initial begin
        #(timeoutNs);
        $display("Watchdog expired before all instructions were checked");
        $display("SIMULATION FAILED");
        $fatal(1, "Timeout");
    end

    function automatic logic [dataWidth-1:0] aluModel(input aluOp_e op,
                                                       input logic [dataWidth-1:0] a,
                                                       input logic [dataWidth-1:0] b);
        case (op)
            aluAdd:  return a + b;
            aluSub:  return a - b;
            aluAnd:  return a & b;
            aluOr:   return a | b;
            aluXor:  return a ^ b;
            aluSlt:  return ($signed(a) < $signed(b)) ? 1 : 0;
            aluSll:  return a << b[3:0]; // Shift amount is 4 bits
            aluSrl:  return a >> b[3:0];
            default: return '0;
        endcase
    endfunction

    task automatic stopOnMismatch(input string sigName, input logic [31:0] got,
                                  input logic [31:0] exp);
        $display("FAIL %s: got 0x%0h, expected 0x%0h", sigName, got, exp);
        $display("SIMULATION FAILED");
        $fatal(1, "Mismatch on %s", sigName);
    endtask

    task automatic checkCommit(input logic expValid, input logic [regAddrW-1:0] expRd,
                               input logic [dataWidth-1:0] expData);
        if (commitValid !== expValid) begin
            stopOnMismatch("commitValid", commitValid, expValid);
        end else if (expValid && commitRd !== expRd) begin
            stopOnMismatch("commitRd", commitRd, expRd);
        end else if (expValid && commitData !== expData) begin
            stopOnMismatch("commitData", commitData, expData);
        end
    endtask

    task automatic checkBranch(input logic expTaken, input logic [dataWidth-1:0] expTarget);
        if (branchTaken !== expTaken) begin
            stopOnMismatch("branchTaken", branchTaken, expTaken);
        end else if (branchTarget !== expTarget) begin
            stopOnMismatch("branchTarget", branchTarget, expTarget);
        end
    endtask

    // Keeps the load result out of the very next instruction
    function automatic logic [regAddrW-1:0] freeReg(input logic [regAddrW-1:0] rs);
        logic [regAddrW-1:0] r;
        r = rs;
        while (lastWasLoad && lastLoadRd != '0 && r == lastLoadRd) begin
            r = $urandom_range(regLimit);
        end
        return r;
    endfunction

    task automatic driveIdle();
        issueValid    = 1'b0;
        issueOp       = aluAdd;
        issueAluSrc   = 1'b0;
        issueRegWrite = 1'b0;
        issueMemWrite = 1'b0;
        issueResSrc   = resAlu;
        issueBranch   = 1'b0;
        issueRs1      = '0;
        issueRs2      = '0;
        issueRd       = '0;
        issueImm      = '0;
        issuePc       = '0;
    endtask

    task automatic genInstr();
        int kind;
        kind          = $urandom_range(8);
        issueValid    = 1'b1;
        issueOp       = aluOp_e'($urandom_range(7));
        issueAluSrc   = $urandom_range(1);
        issueRegWrite = 1'b1;
        issueMemWrite = 1'b0;
        issueResSrc   = resAlu;
        issueBranch   = 1'b0;
        issueRs1      = freeReg($urandom_range(regLimit));
        issueRs2      = freeReg($urandom_range(regLimit));
        issueRd       = $urandom_range(regLimit); // r0 included on purpose
        issueImm      = $urandom();
        issuePc       = $urandom();
        case (kind)
            6, 7: begin // Store or load, small addresses so they collide
                issueOp       = aluAdd;
                issueAluSrc   = 1'b1;
                issueImm      = $urandom_range(15);
                issueRegWrite = (kind == 7);
                issueMemWrite = (kind == 6);
                issueResSrc   = (kind == 7) ? resMem : resAlu;
                if ($urandom_range(1) == 0) begin
                    issueRs1 = '0;
                end
            end
            8: begin
                issueOp       = ($urandom_range(1) == 0) ? aluSub : aluXor;
                issueAluSrc   = 1'b0;
                issueRegWrite = 1'b0;
                issueBranch   = 1'b1;
                if ($urandom_range(1) == 0) begin
                    issueRs2 = issueRs1; // Forces a zero result
                end
            end
            default: ;
        endcase
    endtask

    task automatic modelStep(output logic expTaken, output logic [dataWidth-1:0] expTarget);
        logic [dataWidth-1:0] a;
        logic [dataWidth-1:0] b;
        logic [dataWidth-1:0] res;
        expCommit_t           e;
        a         = modelRegs[issueRs1];
        b         = modelRegs[issueRs2];
        res       = aluModel(issueOp, a, issueAluSrc ? issueImm : b);
        expTarget = issuePc + issueImm;
        expTaken  = issueValid && issueBranch && (res == '0);
        e         = '0;
        if (issueValid) begin
            if (issueMemWrite) begin
                modelMem[res % dmemDepth] = b;
            end
            e.valid = issueRegWrite;
            e.rd    = issueRd;
            e.data  = (issueResSrc == resMem) ? modelMem[res % dmemDepth] : res;
            if (issueRegWrite && issueRd != '0) begin
                modelRegs[issueRd] = e.data;
            end
        end
        expQ.push_back(e);
    endtask

    task automatic runCycle(input logic idle);
        logic                 expTaken;
        logic [dataWidth-1:0] expTarget;
        expCommit_t           e;
        @(posedge clk);
        #1;
        if (idle) begin
            driveIdle();
        end else begin
            genInstr();
        end
        modelStep(expTaken, expTarget);
        lastWasLoad = issueValid && issueRegWrite && (issueResSrc == resMem);
        lastLoadRd  = issueRd;
        #2;                                   // Outputs settled, next edge still ahead
        checkBranch(expTaken, expTarget);
        e = expQ.pop_front();                 // Entry issued two cycles ago
        checkCommit(e.valid, e.rd, e.data);
    endtask

    initial begin
        void'($urandom(32'h60419076));
        rst         = 1'b0;
        lastWasLoad = 1'b0;
        lastLoadRd  = '0;
        issued      = 0;
        driveIdle();
        for (int i = 0; i < (1 << regAddrW); i++) begin
            modelRegs[i] = '0;
        end
        for (int i = 0; i < dmemDepth; i++) begin
            modelMem[i] = '0;
        end
        repeat (resetCycles) @(posedge clk);
        #1 rst = 1'b1;
        // Pipeline is empty out of reset
        expQ.push_back('0);
        expQ.push_back('0);
        while (issued < numInstr) begin
            if ($urandom_range(7) == 0) begin
                runCycle(1'b1);
            end else begin
                runCycle(1'b0);
                issued++;
            end
        end
        repeat (2) runCycle(1'b1);            // Drain the last two commits
        if (dut.props.failCount != 0) begin
            $display("Bound properties reported %0d failures", dut.props.failCount);
            $display("SIMULATION FAILED");
            $fatal(1, "Property failures");
        end else begin
            $display("SIMULATION PASSED");
            $finish;
        end
    end

endmodule

`default_nettype wire

/* tb/backEnd_props.sv */
`timescale 1ns/1ns
`default_nettype none

module backEnd_props (
    input logic clk,
    input logic rst,
    input logic issueValid,
    input logic issueRegWrite,
    input logic branchTaken,
    input logic commitValid
);

    int failCount = 0;

    // Nothing can commit in the first cycle out of reset
    commitIdleAfterReset: assert property (@(posedge clk) $rose(rst) |-> !commitValid)
        else begin
            failCount++;
            $error("commitValid high in the cycle after reset release");
        end

    branchNeedsIssue: assert property (@(posedge clk) disable iff (!rst)
        branchTaken |-> issueValid)
        else begin
            failCount++;
            $error("branchTaken high without a valid issue");
        end

    // Commit lags issue by two stages
    commitTracksIssue: assert property (@(posedge clk) disable iff (!rst)
        commitValid |-> $past(issueValid && issueRegWrite, 2))
        else begin
            failCount++;
            $error("commitValid without a register-writing issue two cycles earlier");
        end

endmodule

bind backEnd backEnd_props props (
    .clk           (clk),
    .rst           (rst),
    .issueValid    (issueValid),
    .issueRegWrite (issueRegWrite),
    .branchTaken   (branchTaken),
    .commitValid   (commitValid)
);

`default_nettype wire
